// File: verilog/axi_mem_pkg.sv
package axi_mem_pkg;

    // ==================================================
    // bus widths
    // ==================================================
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [1:0]  resp_t;

    localparam int WORD_BYTES = $bits(data_t) / 8;
    localparam int BYTE_SHIFT = $clog2(WORD_BYTES);

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // shared by the read and the write channel
    typedef enum logic [1:0] {
        CH_IDLE,
        CH_ACCESS,
        CH_RESP
    } chan_state_e;

    // ==================================================
    // channel payloads
    // ==================================================
    typedef struct packed {
        addr_t addr;
        id_t   id;
    } ar_req_t;

    typedef struct packed {
        data_t data;
        id_t   id;
        resp_t resp;
        logic  last;
    } r_rsp_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } aw_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_req_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_rsp_t;

    // word index, not a byte address
    typedef struct packed {
        addr_t index;
        data_t data;
        strb_t strb;
    } mem_wr_t;

    // span is the window size in bytes, so base + span may wrap
    function automatic logic in_window(addr_t addr, addr_t base, addr_t span);
        addr_t offset;
        offset = addr - base;
        return (addr >= base) && (offset < span);
    endfunction

    function automatic addr_t word_index(addr_t addr, addr_t base);
        return (addr - base) >> BYTE_SHIFT;
    endfunction

endpackage

// File: verilog/mem_array.sv
module mem_array #(
    parameter int unsigned MEM_DEPTH = 256
) (
    input  logic                 clk,

    input  logic                 rd_en,
    input  axi_mem_pkg::addr_t   rd_index,
    output axi_mem_pkg::data_t   rd_data,

    input  logic                 wr_en,
    input  axi_mem_pkg::mem_wr_t wr
);

    import axi_mem_pkg::*;

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    data_t             mem [MEM_DEPTH];
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;

    assign rd_idx = rd_index[IDX_W-1:0];
    assign wr_idx = wr.index[IDX_W-1:0];

    // ==================================================
    // read port
    // ==================================================
    // nonblocking update, so a write on the same edge
    // is not seen here
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (wr.strb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // the ports decode the window, so the array never sees a wild index
    a_rd_index_in_range : assert property (
        @(posedge clk) rd_en |-> (rd_index < MEM_DEPTH)
    ) else $error("read index %0d outside array", rd_index);

    a_wr_index_in_range : assert property (
        @(posedge clk) wr_en |-> (wr.index < MEM_DEPTH)
    ) else $error("write index %0d outside array", wr.index);

endmodule

// File: verilog/axi_read_port.sv
module axi_read_port #(
    parameter int unsigned        MEM_DEPTH = 256,
    parameter axi_mem_pkg::addr_t BASE_ADDR = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst,

    input  axi_mem_pkg::ar_req_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,

    output axi_mem_pkg::r_rsp_t  r,
    output logic                 r_valid,
    input  logic                 r_ready,

    output logic                 rd_en,
    output axi_mem_pkg::addr_t   rd_index,
    input  axi_mem_pkg::data_t   rd_data
);

    import axi_mem_pkg::*;

    localparam addr_t WIN_SPAN = addr_t'(MEM_DEPTH * WORD_BYTES);

    chan_state_e state;
    chan_state_e state_nxt;
    ar_req_t     ar_q;
    logic        in_range;
    logic        ar_fire;

    assign ar_ready = (state == CH_IDLE);
    assign r_valid  = (state == CH_RESP);
    assign ar_fire  = ar_valid && ar_ready;

    // ==================================================
    // state machine
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            CH_IDLE: begin
                if (ar_fire) begin
                    state_nxt = CH_ACCESS;
                end
            end
            // array access always takes one cycle
            CH_ACCESS: state_nxt = CH_RESP;
            CH_RESP: begin
                if (r_ready) begin
                    state_nxt = CH_IDLE;
                end
            end
            default: state_nxt = CH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            ar_q <= ar;
        end
    end

    // ==================================================
    // decode and response
    // ==================================================
    assign in_range = in_window(ar_q.addr, BASE_ADDR, WIN_SPAN);
    assign rd_index = word_index(ar_q.addr, BASE_ADDR);
    assign rd_en    = (state == CH_ACCESS) && in_range;

    // rd_data holds until the next rd_en, which cannot come before r_ready
    always_comb begin
        r.data = in_range ? rd_data : '0;
        r.id   = ar_q.id;
        r.resp = in_range ? RESP_OKAY : RESP_DECERR;
        r.last = 1'b1;
    end

    a_r_stable : assert property (
        @(posedge clk) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r))
    ) else $error("read response changed while waiting for r_ready");

    a_rd_en_after_ar : assert property (
        @(posedge clk) disable iff (rst)
        rd_en |-> $past(ar_fire)
    ) else $error("rd_en not in the cycle right after an AR handshake");

endmodule

// File: verilog/axi_write_port.sv
module axi_write_port #(
    parameter int unsigned        MEM_DEPTH = 256,
    parameter axi_mem_pkg::addr_t BASE_ADDR = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst,

    input  axi_mem_pkg::aw_req_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,

    input  axi_mem_pkg::w_req_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,

    output axi_mem_pkg::b_rsp_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,

    output logic                 wr_en,
    output axi_mem_pkg::mem_wr_t wr
);

    import axi_mem_pkg::*;

    localparam addr_t WIN_SPAN = addr_t'(MEM_DEPTH * WORD_BYTES);

    chan_state_e state;
    chan_state_e state_nxt;
    aw_req_t     aw_q;
    w_req_t      w_q;
    logic        in_range;
    logic        wr_fire;

    // address and data are taken together, never one alone
    assign aw_ready = (state == CH_IDLE);
    assign w_ready  = (state == CH_IDLE);
    assign b_valid  = (state == CH_RESP);
    assign wr_fire  = aw_valid && w_valid && (state == CH_IDLE);

    // ==================================================
    // state machine
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            CH_IDLE: begin
                if (wr_fire) begin
                    state_nxt = CH_ACCESS;
                end
            end
            CH_ACCESS: state_nxt = CH_RESP;
            CH_RESP: begin
                if (b_ready) begin
                    state_nxt = CH_IDLE;
                end
            end
            default: state_nxt = CH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            aw_q <= aw;
            w_q  <= w;
        end
    end

    // ==================================================
    // decode, array write, response
    // ==================================================
    assign in_range = in_window(aw_q.addr, BASE_ADDR, WIN_SPAN);

    // out of window writes never reach the array
    assign wr_en = (state == CH_ACCESS) && in_range;

    always_comb begin
        wr.index = word_index(aw_q.addr, BASE_ADDR);
        wr.data  = w_q.data;
        wr.strb  = w_q.strb;
    end

    // write id, not the read id
    always_comb begin
        b.id   = aw_q.id;
        b.resp = in_range ? RESP_OKAY : RESP_DECERR;
    end

    a_b_hold : assert property (
        @(posedge clk) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b))
    ) else $error("b_valid dropped or b changed before b_ready");

endmodule

// File: verilog/axi_mem.sv
module axi_mem #(
    parameter int unsigned        MEM_DEPTH = 256,
    parameter axi_mem_pkg::addr_t BASE_ADDR = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst,

    input  axi_mem_pkg::ar_req_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output axi_mem_pkg::r_rsp_t  r,
    output logic                 r_valid,
    input  logic                 r_ready,

    input  axi_mem_pkg::aw_req_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_mem_pkg::w_req_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output axi_mem_pkg::b_rsp_t  b,
    output logic                 b_valid,
    input  logic                 b_ready
);

    import axi_mem_pkg::*;

    logic    rd_en;
    addr_t   rd_index;
    data_t   rd_data;
    logic    wr_en;
    mem_wr_t wr;

    // ==================================================
    // read side, write side, shared storage
    // ==================================================
    axi_read_port #(
        .MEM_DEPTH (MEM_DEPTH),
        .BASE_ADDR (BASE_ADDR)
    ) i_read_port (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    axi_write_port #(
        .MEM_DEPTH (MEM_DEPTH),
        .BASE_ADDR (BASE_ADDR)
    ) i_write_port (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_en    (wr_en),
        .wr       (wr)
    );

    mem_array #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_mem_array (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr       (wr)
    );

endmodule

// File: verif/tb_axi_mem.sv
module tb_axi_mem;
    timeunit 1ns;
    timeprecision 100ps;

    import axi_mem_pkg::*;

    // same values as the DUT defaults
    localparam int unsigned MEM_DEPTH = 256;
    localparam addr_t       BASE_ADDR = 32'h8000_0000;
    localparam int          RESP_LAT  = 2;
    localparam int          NUM_TXN   = 70;

    logic    clk = 1'b0;
    logic    rst;
    ar_req_t ar;
    logic    ar_valid;
    logic    ar_ready;
    r_rsp_t  r;
    logic    r_valid;
    logic    r_ready;
    aw_req_t aw;
    logic    aw_valid;
    logic    aw_ready;
    w_req_t  w;
    logic    w_valid;
    logic    w_ready;
    b_rsp_t  b;
    logic    b_valid;
    logic    b_ready;

    int      errors = 0;
    // expected contents, keyed by word index
    data_t   ref_mem [addr_t];

    axi_mem i_dut (.*);

    always #4 clk = ~clk;

    // ==================================================
    // reference model
    // ==================================================
    function automatic addr_t word_addr(int idx);
        return BASE_ADDR + addr_t'(idx) * 8;
    endfunction

    function automatic logic is_mapped(addr_t addr);
        return {1'b0, addr} >= {1'b0, BASE_ADDR}
            && {1'b0, addr} < {1'b0, BASE_ADDR} + 33'(MEM_DEPTH * 8);
    endfunction

    function automatic addr_t index_of(addr_t addr);
        return (addr - BASE_ADDR) / 8;
    endfunction

    function automatic data_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic void model_write(addr_t addr, data_t data, strb_t strb);
        data_t word;
        if (is_mapped(addr)) begin
            word = ref_mem.exists(index_of(addr)) ? ref_mem[index_of(addr)] : '0;
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) begin
                    word[i*8 +: 8] = data[i*8 +: 8];
                end
            end
            ref_mem[index_of(addr)] = word;
        end
    endfunction

    function automatic r_rsp_t read_expect(addr_t addr, id_t id);
        r_rsp_t exp;
        exp.id   = id;
        exp.last = 1'b1;
        exp.data = is_mapped(addr) ? ref_mem[index_of(addr)] : '0;
        exp.resp = is_mapped(addr) ? RESP_OKAY : RESP_DECERR;
        return exp;
    endfunction

    function automatic b_rsp_t b_expect(addr_t addr, id_t id);
        b_rsp_t exp;
        exp.id   = id;
        exp.resp = is_mapped(addr) ? RESP_OKAY : RESP_DECERR;
        return exp;
    endfunction

    // ==================================================
    // checks
    // ==================================================
    task automatic report_error(string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic check_r(string name, r_rsp_t exp, r_rsp_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_b(string name, b_rsp_t exp, b_rsp_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_lat(string name, int exp, int act);
        if (act != exp) begin
            errors++;
            $display("Fail %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // ==================================================
    // transactions
    // ==================================================
    // lat counts rising edges from the handshake edge up to valid
    task automatic write_check(string name, addr_t addr, id_t id, data_t data,
                               strb_t strb, int hold);
        b_rsp_t exp;
        b_rsp_t got;
        int     lat;
        exp = b_expect(addr, id);
        model_write(addr, data, strb);
        @(posedge clk);
        aw       <= {addr, id};
        w        <= {data, strb};
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
        @(negedge clk);
        while (!(aw_ready && w_ready)) @(negedge clk);
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!b_valid) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        got = b;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            if (!b_valid || b !== got || aw_ready || w_ready) begin
                report_error({name, ": write response not held or a ready high while b_ready low"});
            end
        end
        @(posedge clk);
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
        check_b(name, exp, got);
        check_lat(name, RESP_LAT, lat);
    endtask

    task automatic read_check(string name, addr_t addr, id_t id, int hold);
        r_rsp_t exp;
        r_rsp_t got;
        int     lat;
        exp = read_expect(addr, id);
        @(posedge clk);
        ar       <= {addr, id};
        ar_valid <= 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        ar_valid <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!r_valid) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        got = r;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            if (!r_valid || r !== got || ar_ready) begin
                report_error({name, ": read response not held while r_ready low"});
            end
        end
        @(posedge clk);
        r_ready <= 1'b1;
        @(posedge clk);
        r_ready <= 1'b0;
        check_r(name, exp, got);
        check_lat(name, RESP_LAT, lat);
    endtask

    // ==================================================
    // tests
    // ==================================================
    task automatic test_reset();
        @(negedge clk);
        if (r_valid || b_valid || !ar_ready || !aw_ready || !w_ready) begin
            report_error("after reset a valid is high or a ready is low");
        end
    endtask

    task automatic test_full_word();
        int idx [4] = '{0, 1, 100, 255};
        foreach (idx[i]) begin
            write_check("full word write", word_addr(idx[i]), id_t'(i + 3), rand_word(), '1, 0);
            read_check("full word read", word_addr(idx[i]), id_t'(i + 9), 0);
        end
    endtask

    task automatic test_partial();
        write_check("partial base", word_addr(42), 4'h1, 64'h0123_4567_89ab_cdef, '1, 0);
        repeat (8) begin
            write_check("partial write", word_addr(42), id_t'($urandom), rand_word(),
                        strb_t'($urandom), 0);
            read_check("partial read", word_addr(42), id_t'($urandom), 0);
        end
    endtask

    // an aliased write below or above the window would land on word 255 or word 0
    task automatic test_decode();
        write_check("decode setup low", word_addr(0), 4'h2, rand_word(), '1, 0);
        write_check("decode setup high", word_addr(MEM_DEPTH - 1), 4'h3, rand_word(), '1, 0);
        write_check("decode write below", BASE_ADDR - 8, 4'h4, rand_word(), '1, 0);
        write_check("decode write above", word_addr(MEM_DEPTH), 4'h5, rand_word(), '1, 0);
        read_check("decode read below", BASE_ADDR - 8, 4'h6, 0);
        read_check("decode read above", word_addr(MEM_DEPTH), 4'h7, 0);
        read_check("decode read zero", 32'h0, 4'h8, 0);
        read_check("decode unchanged low", word_addr(0), 4'h9, 0);
        read_check("decode unchanged high", word_addr(MEM_DEPTH - 1), 4'ha, 0);
    endtask

    task automatic test_backpressure();
        addr_t addr;
        repeat (6) begin
            addr = word_addr($urandom % MEM_DEPTH);
            write_check("backpressure write", addr, id_t'($urandom), rand_word(), '1,
                        1 + $urandom % 10);
            read_check("backpressure read", addr, id_t'($urandom), 1 + $urandom % 10);
        end
    endtask

    // each round reads the word written in the round before
    task automatic test_concurrent();
        write_check("concurrent setup", word_addr(135), 4'h0, rand_word(), '1, 0);
        for (int i = 0; i < 8; i++) begin
            fork
                write_check("concurrent write", word_addr(136 + i), id_t'(i), rand_word(), '1,
                            $urandom % 4);
                read_check("concurrent read", word_addr(135 + i), id_t'(15 - i), $urandom % 4);
            join
        end
        read_check("concurrent last", word_addr(143), 4'hf, 0);
    endtask

    // w carries different data, so a wrongly taken write would show in the read
    task automatic test_lone_aw();
        write_check("lone aw setup", word_addr(20), 4'h1, rand_word(), '1, 0);
        @(posedge clk);
        aw       <= {word_addr(20), 4'h2};
        w        <= {~ref_mem[20], 8'hff};
        aw_valid <= 1'b1;
        w_valid  <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (b_valid) begin
                report_error("write response without write data");
            end
        end
        @(posedge clk);
        aw_valid <= 1'b0;
        read_check("lone aw unchanged", word_addr(20), 4'h3, 0);
    endtask

    // ==================================================
    // run
    // ==================================================
    initial begin
        repeat (NUM_TXN * 40 + 200) @(posedge clk);
        $display("Error: watchdog expired, the DUT stopped answering");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h914f));
        rst      = 1'b1;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_full_word();
        test_partial();
        test_decode();
        test_backpressure();
        test_concurrent();
        test_lone_aw();
        repeat (2) @(posedge clk);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/axi_mem_pkg.sv
verilog/mem_array.sv
verilog/axi_read_port.sv
verilog/axi_write_port.sv
verilog/axi_mem.sv
verif/tb_axi_mem.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_axi_mem -Mdir obj_dir \
    && ./obj_dir/Vtb_axi_mem | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
